//--- common/overlay_pkg.sv
// Button layout and label strokes for the overlay, sized for a 1024x768 screen
// Stroke offsets are relative to the button corner and limited to OFS_W bits
package overlay_pkg;

  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 11;
  localparam int RGB_W = 12;                       // 4-4-4
  localparam int STATE_W = 3;
  localparam int NUM_STATES = 1 << STATE_W;

  localparam int NUM_BTN = 4;                      // Index order is drawing priority
  localparam int MAX_STROKES = 20;
  localparam int STROKE_CNT_W = $clog2(MAX_STROKES + 1);
  localparam int OFS_W = 7;

  localparam logic [RGB_W-1:0] INK_RGB = 12'h0_0_0;

  // Inclusive rectangle inside a button
  typedef struct packed {
    logic [OFS_W-1:0] x0;
    logic [OFS_W-1:0] x1;
    logic [OFS_W-1:0] y0;
    logic [OFS_W-1:0] y1;
  } stroke_t;

  // Box is half-open, right and bottom edges excluded
  typedef struct packed {
    logic [HCOUNT_W-1:0]     x;
    logic [VCOUNT_W-1:0]     y;
    logic [HCOUNT_W-1:0]     w;
    logic [VCOUNT_W-1:0]     h;
    logic [RGB_W-1:0]        rgb;
    logic [NUM_STATES-1:0]   states;        // Bit n set means shown in state n
    logic [STROKE_CNT_W-1:0] n_strokes;
  } button_t;

  localparam stroke_t NO_STROKE = '0;

  localparam button_t BUTTONS [NUM_BTN] = '{
    '{x: 342, y: 668, w: 100, h: 50, rgb: 12'hF_0_0,
      states: 8'b0000_0010, n_strokes: 14},          // Button 1, red
    '{x: 462, y: 668, w: 100, h: 50, rgb: 12'h0_0_F,
      states: 8'b0000_0100, n_strokes: 6},           // Button 2, blue
    '{x: 582, y: 668, w: 100, h: 50, rgb: 12'h0_F_0,
      states: 8'b0000_0100, n_strokes: 20},          // Button 3, green
    '{x: 422, y: 370, w: 120, h: 60, rgb: 12'hF_7_2,
      states: 8'b0011_1001, n_strokes: 20}           // Central button, orange
  };

  // Each entry is '{x0, x1, y0, y1}
  localparam stroke_t STROKES [NUM_BTN][MAX_STROKES] = '{
    '{
      '{11, 15, 5, 45},
      '{11, 27, 5, 9},
      '{25, 29, 7, 43},
      '{11, 27, 41, 45},
      '{31, 35, 5, 45},
      '{31, 49, 5, 9},
      '{31, 49, 23, 27},
      '{31, 49, 41, 45},
      '{51, 55, 7, 45},
      '{65, 69, 7, 45},
      '{53, 67, 5, 9},
      '{51, 67, 23, 27},
      '{71, 75, 5, 43},
      '{71, 89, 41, 45},
      NO_STROKE, NO_STROKE, NO_STROKE,
      NO_STROKE, NO_STROKE, NO_STROKE
    },
    '{
      '{21, 25, 5, 45},
      '{35, 39, 5, 45},
      '{21, 39, 23, 27},
      '{48, 52, 5, 45},
      '{61, 79, 5, 9},
      '{68, 72, 5, 45},
      NO_STROKE, NO_STROKE, NO_STROKE, NO_STROKE, NO_STROKE,
      NO_STROKE, NO_STROKE, NO_STROKE, NO_STROKE, NO_STROKE,
      NO_STROKE, NO_STROKE, NO_STROKE, NO_STROKE
    },
    '{
      '{6, 22, 5, 9},
      '{6, 22, 23, 27},
      '{6, 22, 41, 45},
      '{6, 10, 7, 23},
      '{18, 22, 27, 43},
      '{24, 40, 5, 9},
      '{30, 34, 5, 45},
      '{44, 54, 5, 9},
      '{44, 56, 23, 27},
      '{42, 46, 7, 45},
      '{52, 56, 7, 45},
      '{58, 62, 5, 45},
      '{70, 74, 5, 45},
      '{63, 66, 13, 16},              // Diagonal of the N, in three steps
      '{67, 70, 17, 20},
      '{71, 74, 18, 21},
      '{76, 80, 5, 45},
      '{88, 92, 7, 43},
      '{76, 90, 5, 9},
      '{76, 90, 41, 45}
    },
    '{
      '{12, 29, 10, 14},
      '{10, 14, 12, 29},
      '{12, 28, 28, 32},
      '{25, 29, 30, 48},
      '{10, 28, 46, 50},
      '{31, 49, 10, 14},
      '{38, 42, 10, 50},
      '{53, 67, 10, 14},
      '{51, 69, 26, 30},
      '{51, 55, 12, 50},
      '{65, 69, 12, 50},
      '{71, 75, 10, 50},
      '{71, 87, 10, 14},
      '{71, 87, 26, 30},
      '{85, 89, 12, 28},
      '{75, 80, 30, 35},              // Leg of the R
      '{80, 85, 35, 40},
      '{85, 89, 40, 50},
      '{91, 109, 10, 14},
      '{98, 102, 10, 50}
    }
  };

endpackage

//--- common/vga_if.sv
// Free-running pixel stream, one pixel per clock, no handshake
interface vga_if;

  import overlay_pkg::*;

  logic [HCOUNT_W-1:0] hcount;
  logic [VCOUNT_W-1:0] vcount;
  logic                hsync;
  logic                vsync;
  logic                hblnk;
  logic                vblnk;
  logic [RGB_W-1:0]    rgb;

  modport out (
    output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

  modport in (
    input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

endinterface

//--- design/button_shape.sv
// Combinational box and label test for one entry of the button table
// Unused stroke slots beyond n_strokes are ignored
module button_shape #(
  parameter int BTN = 0
) (
  input  logic [overlay_pkg::HCOUNT_W-1:0] hcount,
  input  logic [overlay_pkg::VCOUNT_W-1:0] vcount,
  input  logic [overlay_pkg::STATE_W-1:0]  state,
  output logic                             hit,
  output logic                             ink
);

  import overlay_pkg::*;

  localparam button_t DESC = BUTTONS[BTN];

  logic [HCOUNT_W-1:0] dx;
  logic [VCOUNT_W-1:0] dy;
  logic                in_box;
  logic                shown;
  logic                on_stroke;

  // Offsets from the top-left corner, only meaningful inside the box
  assign dx = hcount - DESC.x;
  assign dy = vcount - DESC.y;

  assign in_box = (hcount >= DESC.x) && (dx < DESC.w) &&
                  (vcount >= DESC.y) && (dy < DESC.h);

  assign shown = DESC.states[state];
  assign hit   = in_box && shown;

  always_comb begin
    on_stroke = 1'b0;
    for (int i = 0; i < MAX_STROKES; i++) begin
      if ((i < DESC.n_strokes) &&
          (dx >= STROKES[BTN][i].x0) && (dx <= STROKES[BTN][i].x1) &&
          (dy >= STROKES[BTN][i].y0) && (dy <= STROKES[BTN][i].y1)) begin
        on_stroke = 1'b1;
      end
    end
  end

  assign ink = hit && on_stroke;

endmodule

//--- design/overlay_stage.sv
// Colour select and one-cycle register for the whole stream
// Lowest button index wins where boxes overlap
module overlay_stage (
  input  logic                             clk,
  input  logic                             rst,
  vga_if.in                                stream_in,
  input  logic [overlay_pkg::NUM_BTN-1:0]  hit,
  input  logic [overlay_pkg::NUM_BTN-1:0]  ink,
  vga_if.out                               stream_out
);

  import overlay_pkg::*;

  logic [RGB_W-1:0] rgb_nxt;

  always_comb begin
    rgb_nxt = stream_in.rgb;                  // Pass through outside visible boxes
    // Walk from the highest index so the lowest one is applied last
    for (int i = NUM_BTN - 1; i >= 0; i--) begin
      if (hit[i]) begin
        rgb_nxt = ink[i] ? INK_RGB : BUTTONS[i].rgb;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stream_out.hcount <= '0;
      stream_out.vcount <= '0;
      stream_out.hsync  <= 1'b0;
      stream_out.vsync  <= 1'b0;
      stream_out.hblnk  <= 1'b0;
      stream_out.vblnk  <= 1'b0;
      stream_out.rgb    <= '0;
    end else begin
      stream_out.hcount <= stream_in.hcount;
      stream_out.vcount <= stream_in.vcount;
      stream_out.hsync  <= stream_in.hsync;
      stream_out.vsync  <= stream_in.vsync;
      stream_out.hblnk  <= stream_in.hblnk;
      stream_out.vblnk  <= stream_in.vblnk;
      stream_out.rgb    <= rgb_nxt;
    end
  end

endmodule

//--- design/button_overlay.sv
// Button overlay on a free-running VGA stream, fixed one-cycle latency
// VGA timing and background come from upstream
module button_overlay (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [overlay_pkg::STATE_W-1:0]  state,

  input  logic [overlay_pkg::HCOUNT_W-1:0] hcount_in,
  input  logic [overlay_pkg::VCOUNT_W-1:0] vcount_in,
  input  logic                             hsync_in,
  input  logic                             vsync_in,
  input  logic                             hblnk_in,
  input  logic                             vblnk_in,
  input  logic [overlay_pkg::RGB_W-1:0]    rgb_in,

  output logic [overlay_pkg::HCOUNT_W-1:0] hcount_out,
  output logic [overlay_pkg::VCOUNT_W-1:0] vcount_out,
  output logic                             hsync_out,
  output logic                             vsync_out,
  output logic                             hblnk_out,
  output logic                             vblnk_out,
  output logic [overlay_pkg::RGB_W-1:0]    rgb_out
);

  import overlay_pkg::*;

  logic [NUM_BTN-1:0] hit;
  logic [NUM_BTN-1:0] ink;

  vga_if stream_in ();
  vga_if stream_out ();

  assign stream_in.hcount = hcount_in;
  assign stream_in.vcount = vcount_in;
  assign stream_in.hsync  = hsync_in;
  assign stream_in.vsync  = vsync_in;
  assign stream_in.hblnk  = hblnk_in;
  assign stream_in.vblnk  = vblnk_in;
  assign stream_in.rgb    = rgb_in;

  // One matcher per table entry
  for (genvar b = 0; b < NUM_BTN; b++) begin : g_btn
    button_shape #(
      .BTN(b)
    ) u_shape (
      .hcount(stream_in.hcount),
      .vcount(stream_in.vcount),
      .state (state),
      .hit   (hit[b]),
      .ink   (ink[b])
    );
  end

  overlay_stage u_stage (
    .clk       (clk),
    .rst       (rst),
    .stream_in (stream_in.in),
    .hit       (hit),
    .ink       (ink),
    .stream_out(stream_out.out)
  );

  assign hcount_out = stream_out.hcount;
  assign vcount_out = stream_out.vcount;
  assign hsync_out  = stream_out.hsync;
  assign vsync_out  = stream_out.vsync;
  assign hblnk_out  = stream_out.hblnk;
  assign vblnk_out  = stream_out.vblnk;
  assign rgb_out    = stream_out.rgb;

endmodule

//--- verification/overlay_model.svh
// Reference rules for the 1024x768 button layout, kept apart from the RTL tables
// Included inside the testbench module, holds constants and functions only
`ifndef OVERLAY_MODEL_SVH
`define OVERLAY_MODEL_SVH

localparam int BOX_X [4] = '{342, 462, 582, 422};
localparam int BOX_Y [4] = '{668, 668, 668, 370};
localparam int BOX_W [4] = '{100, 100, 100, 120};
localparam int BOX_H [4] = '{50, 50, 50, 60};
localparam logic [11:0] FILL_RGB [4] = '{12'hF00, 12'h00F, 12'h0F0, 12'hF72};

// Label rectangles of all four buttons back to back, each x0 x1 y0 y1 inclusive
localparam int LABEL_FIRST [4] = '{0, 14, 20, 40};
localparam int LABEL_LEN [4] = '{14, 6, 20, 20};
localparam int LABEL_RECT [60][4] = '{
  '{11, 15, 5, 45}, '{11, 27, 5, 9}, '{25, 29, 7, 43}, '{11, 27, 41, 45},
  '{31, 35, 5, 45}, '{31, 49, 5, 9}, '{31, 49, 23, 27}, '{31, 49, 41, 45},
  '{51, 55, 7, 45}, '{65, 69, 7, 45}, '{53, 67, 5, 9}, '{51, 67, 23, 27},
  '{71, 75, 5, 43}, '{71, 89, 41, 45},
  '{21, 25, 5, 45}, '{35, 39, 5, 45}, '{21, 39, 23, 27}, '{48, 52, 5, 45},
  '{61, 79, 5, 9}, '{68, 72, 5, 45},
  '{6, 22, 5, 9}, '{6, 22, 23, 27}, '{6, 22, 41, 45}, '{6, 10, 7, 23},
  '{18, 22, 27, 43}, '{24, 40, 5, 9}, '{30, 34, 5, 45}, '{44, 54, 5, 9},
  '{44, 56, 23, 27}, '{42, 46, 7, 45}, '{52, 56, 7, 45}, '{58, 62, 5, 45},
  '{70, 74, 5, 45}, '{63, 66, 13, 16}, '{67, 70, 17, 20}, '{71, 74, 18, 21},
  '{76, 80, 5, 45}, '{88, 92, 7, 43}, '{76, 90, 5, 9}, '{76, 90, 41, 45},
  '{12, 29, 10, 14}, '{10, 14, 12, 29}, '{12, 28, 28, 32}, '{25, 29, 30, 48},
  '{10, 28, 46, 50}, '{31, 49, 10, 14}, '{38, 42, 10, 50}, '{53, 67, 10, 14},
  '{51, 69, 26, 30}, '{51, 55, 12, 50}, '{65, 69, 12, 50}, '{71, 75, 10, 50},
  '{71, 87, 10, 14}, '{71, 87, 26, 30}, '{85, 89, 12, 28}, '{75, 80, 30, 35},
  '{80, 85, 35, 40}, '{85, 89, 40, 50}, '{91, 109, 10, 14}, '{98, 102, 10, 50}
};

function automatic bit button_shown(input int b, input int st);
  case (b)
    0:       return st == 1;
    1, 2:    return st == 2;
    default: return st inside {0, 3, 4, 5};      // Central button
  endcase
endfunction

// Half-open box, right column and bottom row excluded
function automatic bit inside_box(input int b, input int hc, input int vc);
  return (hc >= BOX_X[b]) && (hc < BOX_X[b] + BOX_W[b]) &&
         (vc >= BOX_Y[b]) && (vc < BOX_Y[b] + BOX_H[b]);
endfunction

function automatic bit on_label(input int b, input int hc, input int vc);
  int dx;
  int dy;
  dx = hc - BOX_X[b];
  dy = vc - BOX_Y[b];
  for (int i = LABEL_FIRST[b]; i < LABEL_FIRST[b] + LABEL_LEN[b]; i++) begin
    if ((dx >= LABEL_RECT[i][0]) && (dx <= LABEL_RECT[i][1]) &&
        (dy >= LABEL_RECT[i][2]) && (dy <= LABEL_RECT[i][3])) begin
      return 1'b1;
    end
  end
  return 1'b0;
endfunction

// Visible button under the pixel, lowest index first, -1 for none
function automatic int visible_button(input int st, input int hc, input int vc);
  for (int b = 0; b < 4; b++) begin
    if (inside_box(b, hc, vc) && button_shown(b, st)) begin
      return b;
    end
  end
  return -1;
endfunction

function automatic logic [11:0] expected_rgb(input int st, input int hc, input int vc,
                                             input logic [11:0] rgb_in);
  int b;
  b = visible_button(st, hc, vc);
  if (b < 0) begin
    return rgb_in;
  end
  if (on_label(b, hc, vc)) begin
    return 12'h000;                                // Label ink is black
  end
  return FILL_RGB[b];
endfunction

`endif

//--- verification/tb_button_overlay.sv
// Random pixel stream through button_overlay with concurrent assertion checks
// Expected values use overlay_model.svh and the one-cycle latency of the stream
module tb_button_overlay;

  timeunit 1ns;
  timeprecision 1ps;

  import overlay_pkg::*;

  localparam int SEED = 46619;
  localparam int RESET_CYCLES = 16;
  localparam int RUN_CYCLES = 20000;
  localparam int DRAIN_TIMEOUT = 8;

  typedef enum int {CLS_RESET, CLS_PASS, CLS_FILL, CLS_INK} pixel_class_e;

  logic                clk = 1'b0;
  logic                rst;
  logic [STATE_W-1:0]  state;
  logic [HCOUNT_W-1:0] hcount_in;
  logic [VCOUNT_W-1:0] vcount_in;
  logic                hsync_in;
  logic                vsync_in;
  logic                hblnk_in;
  logic                vblnk_in;
  logic [RGB_W-1:0]    rgb_in;
  logic [HCOUNT_W-1:0] hcount_out;
  logic [VCOUNT_W-1:0] vcount_out;
  logic                hsync_out;
  logic                vsync_out;
  logic                hblnk_out;
  logic                vblnk_out;
  logic [RGB_W-1:0]    rgb_out;
  logic [37:0]         out_bus;

  // Pixel taken on the previous rising edge
  logic                armed = 1'b0;
  pixel_class_e        exp_cls = CLS_RESET;
  logic [HCOUNT_W-1:0] exp_hcount = '0;
  logic [VCOUNT_W-1:0] exp_vcount = '0;
  logic                exp_hsync = 1'b0;
  logic                exp_vsync = 1'b0;
  logic                exp_hblnk = 1'b0;
  logic                exp_vblnk = 1'b0;
  logic [RGB_W-1:0]    exp_rgb = '0;

  int fill_seen [4];
  int ink_seen [4];
  int hidden_seen [4];
  int no_button_seen = 0;                          // Box pixels in states 6 and 7
  int edge_out_seen = 0;
  int edge_in_seen = 0;

  `include "overlay_model.svh"

  button_overlay DUT (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .hcount_in (hcount_in),
    .vcount_in (vcount_in),
    .hsync_in  (hsync_in),
    .vsync_in  (vsync_in),
    .hblnk_in  (hblnk_in),
    .vblnk_in  (vblnk_in),
    .rgb_in    (rgb_in),
    .hcount_out(hcount_out),
    .vcount_out(vcount_out),
    .hsync_out (hsync_out),
    .vsync_out (vsync_out),
    .hblnk_out (hblnk_out),
    .vblnk_out (vblnk_out),
    .rgb_out   (rgb_out)
  );

  assign out_bus = {hcount_out, vcount_out, hsync_out, vsync_out, hblnk_out, vblnk_out, rgb_out};

  always #20 clk = ~clk;

  function automatic pixel_class_e classify(input logic r, input int st, input int hc,
                                            input int vc);
    int b;
    if (r) begin
      return CLS_RESET;
    end
    b = visible_button(st, hc, vc);
    if (b < 0) begin
      return CLS_PASS;
    end
    return on_label(b, hc, vc) ? CLS_INK : CLS_FILL;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("RESULT: FAIL");
    $display("** Error: %s expected %0h actual %0h", name, exp, act);
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic drive_pixel();
    int b;
    state    = STATE_W'($urandom % 8);
    hsync_in = 1'($urandom % 2);
    vsync_in = 1'($urandom % 2);
    hblnk_in = 1'($urandom % 2);
    vblnk_in = 1'($urandom % 2);
    rgb_in   = RGB_W'($urandom % 4096);
    if ($urandom % 4 != 0) begin                   // Near a button with the box widened by 4
      b = int'($urandom % 4);
      hcount_in = HCOUNT_W'(BOX_X[b] - 4 + int'($urandom % (BOX_W[b] + 8)));
      vcount_in = VCOUNT_W'(BOX_Y[b] - 4 + int'($urandom % (BOX_H[b] + 8)));
    end else begin
      hcount_in = HCOUNT_W'($urandom % 1024);
      vcount_in = VCOUNT_W'($urandom % 768);
    end
  endtask

  task automatic note_reach(input int st, input int hc, input int vc);
    for (int i = 0; i < 4; i++) begin
      if (inside_box(i, hc, vc)) begin
        if (!button_shown(i, st)) begin
          hidden_seen[i]++;
        end else if (on_label(i, hc, vc)) begin
          ink_seen[i]++;
        end else begin
          fill_seen[i]++;
        end
        if (st >= 6) begin
          no_button_seen++;
        end
      end
      if (button_shown(i, st)) begin
        if ((hc == BOX_X[i] + BOX_W[i] && vc >= BOX_Y[i] && vc < BOX_Y[i] + BOX_H[i]) ||
            (vc == BOX_Y[i] + BOX_H[i] && hc >= BOX_X[i] && hc < BOX_X[i] + BOX_W[i])) begin
          edge_out_seen++;                         // First pixel past the box
        end
        if (inside_box(i, hc, vc) &&
            (hc == BOX_X[i] + BOX_W[i] - 1 || vc == BOX_Y[i] + BOX_H[i] - 1)) begin
          edge_in_seen++;
        end
      end
    end
  endtask

  function automatic int count_missed();
    int missed;
    missed = 0;
    for (int i = 0; i < 4; i++) begin
      if (fill_seen[i] == 0 || ink_seen[i] == 0 || hidden_seen[i] == 0) begin
        $display("Stimulus missed the fill, label or hidden case of button index %0d", i);
        missed++;
      end
    end
    if (no_button_seen == 0) begin
      $display("Stimulus never put a box pixel in state 6 or 7");
      missed++;
    end
    if (edge_out_seen == 0 || edge_in_seen == 0) begin
      $display("Stimulus never reached both sides of a right or bottom box edge");
      missed++;
    end
    return missed;
  endfunction

  always @(posedge clk) begin
    armed      <= 1'b1;
    exp_cls    <= classify(rst, int'(state), int'(hcount_in), int'(vcount_in));
    exp_hcount <= hcount_in;
    exp_vcount <= vcount_in;
    exp_hsync  <= hsync_in;
    exp_vsync  <= vsync_in;
    exp_hblnk  <= hblnk_in;
    exp_vblnk  <= vblnk_in;
    exp_rgb    <= expected_rgb(int'(state), int'(hcount_in), int'(vcount_in), rgb_in);
    if (!rst) begin
      note_reach(int'(state), int'(hcount_in), int'(vcount_in));
    end
  end

  a_reset: assert property (@(posedge clk) armed && exp_cls == CLS_RESET |-> out_bus == '0)
    else report_mismatch("out_bus", 64'h0, 64'($sampled(out_bus)));

  a_hcount: assert property (@(posedge clk) armed && exp_cls != CLS_RESET |->
      hcount_out == exp_hcount)
    else report_mismatch("hcount_out", 64'($sampled(exp_hcount)), 64'($sampled(hcount_out)));

  a_vcount: assert property (@(posedge clk) armed && exp_cls != CLS_RESET |->
      vcount_out == exp_vcount)
    else report_mismatch("vcount_out", 64'($sampled(exp_vcount)), 64'($sampled(vcount_out)));

  a_hsync: assert property (@(posedge clk) armed && exp_cls != CLS_RESET |->
      hsync_out == exp_hsync)
    else report_mismatch("hsync_out", 64'($sampled(exp_hsync)), 64'($sampled(hsync_out)));

  a_vsync: assert property (@(posedge clk) armed && exp_cls != CLS_RESET |->
      vsync_out == exp_vsync)
    else report_mismatch("vsync_out", 64'($sampled(exp_vsync)), 64'($sampled(vsync_out)));

  a_hblnk: assert property (@(posedge clk) armed && exp_cls != CLS_RESET |->
      hblnk_out == exp_hblnk)
    else report_mismatch("hblnk_out", 64'($sampled(exp_hblnk)), 64'($sampled(hblnk_out)));

  a_vblnk: assert property (@(posedge clk) armed && exp_cls != CLS_RESET |->
      vblnk_out == exp_vblnk)
    else report_mismatch("vblnk_out", 64'($sampled(exp_vblnk)), 64'($sampled(vblnk_out)));

  a_pass: assert property (@(posedge clk) armed && exp_cls == CLS_PASS |-> rgb_out == exp_rgb)
    else report_mismatch("rgb_out", 64'($sampled(exp_rgb)), 64'($sampled(rgb_out)));

  a_fill: assert property (@(posedge clk) armed && exp_cls == CLS_FILL |-> rgb_out == exp_rgb)
    else report_mismatch("rgb_out", 64'($sampled(exp_rgb)), 64'($sampled(rgb_out)));

  a_ink: assert property (@(posedge clk) armed && exp_cls == CLS_INK |-> rgb_out == 12'h000)
    else report_mismatch("rgb_out", 64'h0, 64'($sampled(rgb_out)));

  initial begin
    logic [HCOUNT_W-1:0] last_hc;
    logic [VCOUNT_W-1:0] last_vc;
    int                  waited;
    void'($urandom(SEED));
    rst = 1'b1;
    drive_pixel();
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(negedge clk);
      drive_pixel();
    end
    rst = 1'b0;                                    // After the 16th rising edge
    repeat (RUN_CYCLES) begin
      @(negedge clk);
      drive_pixel();
    end
    last_hc = hcount_in;
    last_vc = vcount_in;
    waited = 0;
    @(negedge clk);
    while ((hcount_out != last_hc || vcount_out != last_vc) && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (waited >= DRAIN_TIMEOUT) begin
      $display("RESULT: FAIL");
      $fatal(1, "Timed out waiting for the last pixel to reach the output");
    end
    @(negedge clk);                                // Lets the last rgb check run
    if (count_missed() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "Stimulus did not reach every required case");
    end
  end

endmodule

//--- list.f
+incdir+verification
common/overlay_pkg.sv
common/vga_if.sv
design/button_shape.sv
design/overlay_stage.sv
design/button_overlay.sv
verification/tb_button_overlay.sv
